/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tb_mmu_top
FILELIST = list.f
BUILD    = obj_dir
PASS     = Done: no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out=$$(./$(BUILD)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf $(BUILD)

/* csr_pkg.sv */
`default_nettype none

package csr_pkg;

    // current privilege level from crmd
    typedef logic [1:0] plv_t;

    // only these two levels have a window enable
    localparam plv_t PLV0 = 2'd0;
    localparam plv_t PLV3 = 2'd3;

    // top three address bits, used for the window vseg and pseg
    typedef logic [2:0] seg_t;

endpackage

`default_nettype wire

/* dmw_match.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mmu_defs.svh"

module dmw_match (
    input  wire [`VA_W-1:0]    vaddr,
    input  wire csr_pkg::plv_t plv,
    input  wire                dmw0_plv0,
    input  wire                dmw0_plv3,
    input  wire mmu_pkg::mat_t dmw0_mat,
    input  wire csr_pkg::seg_t dmw0_vseg,
    input  wire csr_pkg::seg_t dmw0_pseg,
    input  wire                dmw1_plv0,
    input  wire                dmw1_plv3,
    input  wire mmu_pkg::mat_t dmw1_mat,
    input  wire csr_pkg::seg_t dmw1_vseg,
    input  wire csr_pkg::seg_t dmw1_pseg,
    output logic               dmw_hit,
    output logic [`PA_W-1:0]   dmw_paddr,
    output mmu_pkg::mat_t      dmw_mat
);
    import csr_pkg::*;
    import mmu_pkg::*;

    logic plv_ok0;
    logic plv_ok1;
    logic win0_hit;
    logic win1_hit;

    // levels 1 and 2 have no enable bit, so they never hit a window
    assign plv_ok0 = (plv == PLV0 && dmw0_plv0) || (plv == PLV3 && dmw0_plv3);
    assign plv_ok1 = (plv == PLV0 && dmw1_plv0) || (plv == PLV3 && dmw1_plv3);

    assign win0_hit = plv_ok0 && (vaddr[31:29] == dmw0_vseg);
    assign win1_hit = plv_ok1 && (vaddr[31:29] == dmw1_vseg);

    assign dmw_hit = win0_hit || win1_hit;

    // window 0 wins when both match
    always_comb begin
        dmw_paddr = '0;
        dmw_mat   = '0;
        if (win0_hit) begin
            dmw_paddr = {dmw0_pseg, vaddr[28:0]};
            dmw_mat   = dmw0_mat;
        end else if (win1_hit) begin
            dmw_paddr = {dmw1_pseg, vaddr[28:0]};
            dmw_mat   = dmw1_mat;
        end
    end

endmodule

`default_nettype wire

/* fill_index_counter.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mmu_defs.svh"

module fill_index_counter (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   fill_advance,
    output logic [`TLB_IDX_W-1:0] fill_index
);

    // round robin over all entries, moves only when a fill completes
    always_ff @(posedge clk) begin
        if (reset) begin
            fill_index <= '0;
        end else if (fill_advance) begin
            if (fill_index == `TLB_IDX_W'(`TLB_ENTRIES - 1)) begin
                fill_index <= '0;
            end else begin
                fill_index <= fill_index + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
mmu_pkg.sv
csr_pkg.sv
dmw_match.sv
tlb_array.sv
fill_index_counter.sv
translate_ctrl.sv
tlb_out.sv
mmu_top.sv
tb_mmu_top.sv

/* mmu_defs.svh */
`ifndef MMU_DEFS_SVH
`define MMU_DEFS_SVH

// TLB geometry
`define TLB_ENTRIES 16
`define TLB_IDX_W   4

// virtual and physical address widths
`define VA_W 32
`define PA_W 32

// page-size codes, log2 of the page size in bytes
`define PS_4K 12
`define PS_2M 21

`endif

/* mmu_pkg.sv */
`default_nettype none

package mmu_pkg;

    // address mode, encoded as {crmd_pg, crmd_da}
    typedef enum logic [1:0] {
        AD_NONE = 2'b00,
        DIRECT  = 2'b01,
        MAP     = 2'b10,
        AD_BOTH = 2'b11
    } ad_mode_t;

    // memory access type
    typedef logic [1:0] mat_t;

    // page-size field, holds log2 of the page size
    typedef logic [5:0] ps_t;

    // one TLB entry maps a single page
    typedef struct packed {
        logic       e;
        logic       g;
        logic [9:0] asid;
        // virtual address bits 31 to 13
        logic [18:0] vppn;
        ps_t        ps;
        logic [19:0] pfn;
        mat_t       mat;
    } tlb_entry_t;

endpackage

`default_nettype wire

/* mmu_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mmu_defs.svh"

module mmu_top (
    input  wire                clk,
    input  wire                reset,
    input  wire                req,
    input  wire [`VA_W-1:0]    s0_vaddr,
    input  wire [`VA_W-1:0]    s1_vaddr,
    input  wire                crmd_da,
    input  wire                crmd_pg,
    input  wire csr_pkg::plv_t crmd_plv,
    input  wire [9:0]          asid,
    input  wire                dmw0_plv0,
    input  wire                dmw0_plv3,
    input  wire mmu_pkg::mat_t dmw0_mat,
    input  wire csr_pkg::seg_t dmw0_vseg,
    input  wire csr_pkg::seg_t dmw0_pseg,
    input  wire                dmw1_plv0,
    input  wire                dmw1_plv3,
    input  wire mmu_pkg::mat_t dmw1_mat,
    input  wire csr_pkg::seg_t dmw1_vseg,
    input  wire csr_pkg::seg_t dmw1_pseg,
    input  wire                fill_req,
    input  wire [18:0]         fill_vppn,
    input  wire mmu_pkg::ps_t  fill_ps,
    input  wire [9:0]          fill_asid,
    input  wire                fill_g,
    input  wire [19:0]         fill_pfn,
    input  wire mmu_pkg::mat_t fill_mat,
    input  wire                fill_e,
    output logic               ack,
    output logic               fill_ack,
    output logic [`PA_W-1:0]   s0_paddr,
    output logic [`PA_W-1:0]   s1_paddr,
    output mmu_pkg::mat_t      s0_mat,
    output mmu_pkg::mat_t      s1_mat,
    output logic               s0_hit,
    output logic               s1_hit
);
    import mmu_pkg::*;

    logic                  addr_load;
    logic                  result_load;
    logic                  tlb_we;
    logic                  fill_advance;
    logic [`TLB_IDX_W-1:0] fill_index;
    tlb_entry_t            fill_entry;
    ad_mode_t              ad_mode;
    logic [`VA_W-1:0]      s0_vaddr_q;
    logic [`VA_W-1:0]      s1_vaddr_q;
    logic                  s0_dmw_hit;
    logic                  s1_dmw_hit;
    logic [`PA_W-1:0]      s0_dmw_paddr;
    logic [`PA_W-1:0]      s1_dmw_paddr;
    mat_t                  s0_dmw_mat;
    mat_t                  s1_dmw_mat;
    logic [19:0]           s0_pfn;
    logic [19:0]           s1_pfn;
    ps_t                   s0_found_ps;
    ps_t                   s1_found_ps;
    mat_t                  s0_tlb_mat;
    mat_t                  s1_tlb_mat;
    logic [`PA_W-1:0]      s0_paddr_c;
    logic [`PA_W-1:0]      s1_paddr_c;
    mat_t                  s0_mat_c;
    mat_t                  s1_mat_c;
    logic                  s0_hit_c;
    logic                  s1_hit_c;

    // {pg, da} of 01 is direct and 10 is mapped, the rest fall to invalid codes
    assign ad_mode = ad_mode_t'({crmd_pg, crmd_da});

    always_comb begin
        fill_entry.e    = fill_e;
        fill_entry.g    = fill_g;
        fill_entry.asid = fill_asid;
        fill_entry.vppn = fill_vppn;
        fill_entry.ps   = fill_ps;
        fill_entry.pfn  = fill_pfn;
        fill_entry.mat  = fill_mat;
    end

    always_ff @(posedge clk) begin
        if (addr_load) begin
            s0_vaddr_q <= s0_vaddr;
            s1_vaddr_q <= s1_vaddr;
        end
    end

    // results are held here for the whole time ack is high
    always_ff @(posedge clk) begin
        if (reset) begin
            s0_paddr <= '0;
            s1_paddr <= '0;
            s0_mat   <= '0;
            s1_mat   <= '0;
            s0_hit   <= 1'b0;
            s1_hit   <= 1'b0;
        end else if (result_load) begin
            s0_paddr <= s0_paddr_c;
            s1_paddr <= s1_paddr_c;
            s0_mat   <= s0_mat_c;
            s1_mat   <= s1_mat_c;
            s0_hit   <= s0_hit_c;
            s1_hit   <= s1_hit_c;
        end
    end

    translate_ctrl u_ctrl (
        .clk(clk), .reset(reset), .req(req), .fill_req(fill_req),
        .ack(ack), .fill_ack(fill_ack), .addr_load(addr_load),
        .result_load(result_load), .tlb_we(tlb_we), .fill_advance(fill_advance)
    );

    fill_index_counter u_fill_idx (
        .clk(clk), .reset(reset), .fill_advance(fill_advance), .fill_index(fill_index)
    );

    // found flags are implied by a nonzero found_ps, so they stay open here
    tlb_array u_tlb (
        .clk(clk), .reset(reset), .we(tlb_we), .windex(fill_index),
        .wentry(fill_entry), .asid(asid),
        .s0_vaddr(s0_vaddr_q), .s1_vaddr(s1_vaddr_q),
        .s0_found(), .s1_found(),
        .s0_pfn(s0_pfn), .s1_pfn(s1_pfn),
        .s0_found_ps(s0_found_ps), .s1_found_ps(s1_found_ps),
        .s0_tlb_mat(s0_tlb_mat), .s1_tlb_mat(s1_tlb_mat)
    );

    dmw_match u_dmw_s0 (
        .vaddr(s0_vaddr_q), .plv(crmd_plv),
        .dmw0_plv0(dmw0_plv0), .dmw0_plv3(dmw0_plv3), .dmw0_mat(dmw0_mat),
        .dmw0_vseg(dmw0_vseg), .dmw0_pseg(dmw0_pseg),
        .dmw1_plv0(dmw1_plv0), .dmw1_plv3(dmw1_plv3), .dmw1_mat(dmw1_mat),
        .dmw1_vseg(dmw1_vseg), .dmw1_pseg(dmw1_pseg),
        .dmw_hit(s0_dmw_hit), .dmw_paddr(s0_dmw_paddr), .dmw_mat(s0_dmw_mat)
    );

    dmw_match u_dmw_s1 (
        .vaddr(s1_vaddr_q), .plv(crmd_plv),
        .dmw0_plv0(dmw0_plv0), .dmw0_plv3(dmw0_plv3), .dmw0_mat(dmw0_mat),
        .dmw0_vseg(dmw0_vseg), .dmw0_pseg(dmw0_pseg),
        .dmw1_plv0(dmw1_plv0), .dmw1_plv3(dmw1_plv3), .dmw1_mat(dmw1_mat),
        .dmw1_vseg(dmw1_vseg), .dmw1_pseg(dmw1_pseg),
        .dmw_hit(s1_dmw_hit), .dmw_paddr(s1_dmw_paddr), .dmw_mat(s1_dmw_mat)
    );

    tlb_out u_out (
        .ad_mode(ad_mode),
        .s0_dmw_hit(s0_dmw_hit), .s1_dmw_hit(s1_dmw_hit),
        .s0_vaddr(s0_vaddr_q), .s1_vaddr(s1_vaddr_q),
        .s0_dmw_paddr(s0_dmw_paddr), .s1_dmw_paddr(s1_dmw_paddr),
        .s0_dmw_mat(s0_dmw_mat), .s1_dmw_mat(s1_dmw_mat),
        .s0_tlb_mat(s0_tlb_mat), .s1_tlb_mat(s1_tlb_mat),
        .s0_pfn(s0_pfn), .s1_pfn(s1_pfn),
        .s0_found_ps(s0_found_ps), .s1_found_ps(s1_found_ps),
        .s0_paddr(s0_paddr_c), .s1_paddr(s1_paddr_c),
        .s0_mat(s0_mat_c), .s1_mat(s1_mat_c),
        .s0_hit(s0_hit_c), .s1_hit(s1_hit_c)
    );

endmodule

`default_nettype wire

/* tb_mmu_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mmu_defs.svh"

module tb_mmu_top;
    import mmu_pkg::*;
    import csr_pkg::*;

    localparam int          RESET_CYCLES = 5;
    localparam int          ROW_CYCLES   = 40;
    localparam logic [31:0] WIN_OFF      = 32'h1FFF_FFFF;
    localparam logic [31:0] PAGE_4K      = 32'h0000_0FFF;
    localparam logic [31:0] PAGE_2M      = 32'h001F_FFFF;
    localparam ps_t         P4K          = 6'(`PS_4K);
    localparam ps_t         P2M          = 6'(`PS_2M);

    typedef struct packed {
        logic plv0;
        logic plv3;
        mat_t mat;
        seg_t vseg;
        seg_t pseg;
    } win_t;

    typedef struct packed {
        bit               is_fill;
        bit               with_fill;
        bit               da;
        bit               pg;
        plv_t             plv;
        logic [9:0]       asid;
        win_t             win0;
        win_t             win1;
        logic [`VA_W-1:0] s0_base;
        logic [`VA_W-1:0] s0_mask;
        logic [`VA_W-1:0] s1_base;
        logic [`VA_W-1:0] s1_mask;
        tlb_entry_t       entry;
    } row_t;

    typedef struct packed {
        logic [`PA_W-1:0] paddr;
        mat_t             mat;
        logic             hit;
    } result_t;

    logic             clk;
    logic             reset;
    logic             req;
    logic             fill_req;
    logic             crmd_da;
    logic             crmd_pg;
    plv_t             crmd_plv;
    logic [9:0]       asid;
    logic [`VA_W-1:0] s0_vaddr;
    logic [`VA_W-1:0] s1_vaddr;
    win_t             dmw0;
    win_t             dmw1;
    tlb_entry_t       fill;
    logic             ack;
    logic             fill_ack;
    logic [`PA_W-1:0] s0_paddr;
    logic [`PA_W-1:0] s1_paddr;
    mat_t             s0_mat;
    mat_t             s1_mat;
    logic             s0_hit;
    logic             s1_hit;

    row_t       rows[$];
    win_t       cur_win0;
    win_t       cur_win1;
    tlb_entry_t model_tlb [`TLB_ENTRIES];
    int         model_idx;
    int         err_count;
    bit         rows_ready = 1'b0;

    mmu_top dut0 (
        .clk(clk), .reset(reset), .req(req),
        .s0_vaddr(s0_vaddr), .s1_vaddr(s1_vaddr),
        .crmd_da(crmd_da), .crmd_pg(crmd_pg), .crmd_plv(crmd_plv), .asid(asid),
        .dmw0_plv0(dmw0.plv0), .dmw0_plv3(dmw0.plv3), .dmw0_mat(dmw0.mat),
        .dmw0_vseg(dmw0.vseg), .dmw0_pseg(dmw0.pseg),
        .dmw1_plv0(dmw1.plv0), .dmw1_plv3(dmw1.plv3), .dmw1_mat(dmw1.mat),
        .dmw1_vseg(dmw1.vseg), .dmw1_pseg(dmw1.pseg),
        .fill_req(fill_req), .fill_vppn(fill.vppn), .fill_ps(fill.ps),
        .fill_asid(fill.asid), .fill_g(fill.g), .fill_pfn(fill.pfn),
        .fill_mat(fill.mat), .fill_e(fill.e),
        .ack(ack), .fill_ack(fill_ack),
        .s0_paddr(s0_paddr), .s1_paddr(s1_paddr),
        .s0_mat(s0_mat), .s1_mat(s1_mat), .s0_hit(s0_hit), .s1_hit(s1_hit)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_now(input string why);
        $display("Done: errors found");
        $fatal(1, "%s", why);
    endtask

    task automatic check_paddr(input string name, input logic [`PA_W-1:0] got, exp);
        if (got !== exp) begin
            $display("** Error at %0.1f ns: %s is %h, expected %h", $realtime, name, got, exp);
            err_count++;
            fail_now("stopped at the first mismatch");
        end
    endtask

    task automatic check_mat(input string name, input mat_t got, exp);
        if (got !== exp) begin
            $display("** Error at %0.1f ns: %s is %0d, expected %0d", $realtime, name, got, exp);
            err_count++;
            fail_now("stopped at the first mismatch");
        end
    endtask

    task automatic check_hit(input string name, input bit got, exp);
        if (got !== exp) begin
            $display("** Error at %0.1f ns: %s is %0d, expected %0d", $realtime, name, got, exp);
            err_count++;
            fail_now("stopped at the first mismatch");
        end
    endtask

    function automatic bit win_hits(input win_t w, input plv_t plv, input logic [31:0] va);
        return va[31:29] == w.vseg && ((plv == 2'd0 && w.plv0) || (plv == 2'd3 && w.plv3));
    endfunction

    // reference translation of one port, before any fill raised with this lookup
    function automatic result_t model_port(input row_t r, input logic [`VA_W-1:0] va);
        result_t     res;
        tlb_entry_t  ent;
        logic [31:0] low;
        bit          found;
        int          shift;
        int          i;
        res = '0;
        ent = '0;
        found = 1'b0;
        if (r.da && !r.pg) begin
            res.paddr = va;
            res.hit = 1'b1;
        end else if (!r.da && r.pg) begin
            if (win_hits(r.win0, r.plv, va)) begin
                res.paddr = {r.win0.pseg, va[28:0]};
                res.mat = r.win0.mat;
                res.hit = 1'b1;
            end else if (win_hits(r.win1, r.plv, va)) begin
                res.paddr = {r.win1.pseg, va[28:0]};
                res.mat = r.win1.mat;
                res.hit = 1'b1;
            end else begin
                for (i = 0; i < `TLB_ENTRIES; i++) begin
                    shift = (model_tlb[i].ps == P2M) ? 21 : 13;
                    if (!found && model_tlb[i].e
                            && (model_tlb[i].g || model_tlb[i].asid == r.asid)
                            && ({model_tlb[i].vppn, 13'b0} >> shift) == (va >> shift)) begin
                        found = 1'b1;
                        ent = model_tlb[i];
                    end
                end
                if (found && (ent.ps == P4K || ent.ps == P2M)) begin
                    low = (32'd1 << ent.ps) - 32'd1;
                    res.paddr = ({ent.pfn, 12'b0} & ~low) | (va & low);
                    res.hit = 1'b1;
                end
                res.mat = ent.mat;
            end
        end
        return res;
    endfunction

    function automatic void add_lookup(input bit da, pg, input plv_t plv,
            input logic [9:0] id, input logic [31:0] b0, m0, b1, m1,
            input bit with_fill = 1'b0);
        row_t r;
        r = '0;
        r.with_fill = with_fill;
        r.da = da;
        r.pg = pg;
        r.plv = plv;
        r.asid = id;
        r.win0 = cur_win0;
        r.win1 = cur_win1;
        r.s0_base = b0;
        r.s0_mask = m0;
        r.s1_base = b1;
        r.s1_mask = m1;
        rows.push_back(r);
    endfunction

    function automatic void add_fill(input logic [31:0] va, input ps_t ps,
            input logic [9:0] id, input bit g, input logic [19:0] pfn,
            input mat_t mat, input bit e);
        row_t r;
        r = '0;
        r.is_fill = 1'b1;
        r.entry.e = e;
        r.entry.g = g;
        r.entry.asid = id;
        r.entry.vppn = va[31:13];
        r.entry.ps = ps;
        r.entry.pfn = pfn;
        r.entry.mat = mat;
        rows.push_back(r);
    endfunction

    function automatic void build_table();
        int k;
        // windows stay enabled in direct mode and must have no effect
        cur_win0 = '{1'b1, 1'b1, 2'd1, 3'd5, 3'd0};
        cur_win1 = '{1'b1, 1'b1, 2'd2, 3'd4, 3'd1};
        add_lookup(1'b1, 1'b0, 2'd0, 10'd0, 32'h0, '1, 32'h0, '1);
        add_lookup(1'b1, 1'b0, 2'd3, 10'd0, 32'h0, '1, 32'h0, '1);
        cur_win0.plv3 = 1'b0;
        add_lookup(1'b0, 1'b1, 2'd0, 10'd0, 32'hA000_0000, WIN_OFF, 32'h8000_0000, WIN_OFF);
        add_lookup(1'b0, 1'b1, 2'd3, 10'd0, 32'hA000_0000, WIN_OFF, 32'h8000_0000, WIN_OFF);
        add_lookup(1'b0, 1'b1, 2'd2, 10'd0, 32'hA000_0000, WIN_OFF, 32'h8000_0000, WIN_OFF);
        // both windows on segment 5
        cur_win1.vseg = 3'd5;
        add_lookup(1'b0, 1'b1, 2'd0, 10'd0, 32'hA000_0000, WIN_OFF, 32'hA000_0000, WIN_OFF);
        cur_win0 = '0;
        cur_win1 = '0;
        add_fill(32'h0040_6000, P4K, 10'd5, 1'b0, 20'hABCDE, 2'd1, 1'b1);
        add_fill(32'h1460_0000, P2M, 10'd5, 1'b0, 20'h12345, 2'd2, 1'b1);
        add_lookup(1'b0, 1'b1, 2'd0, 10'd5, 32'h0040_6000, PAGE_4K, 32'h1460_0000, PAGE_2M);
        add_lookup(1'b0, 1'b1, 2'd3, 10'd5, 32'h1460_0000, PAGE_2M, 32'h0040_6000, PAGE_4K);
        add_lookup(1'b0, 1'b1, 2'd0, 10'd6, 32'h0040_6000, PAGE_4K, 32'h1460_0000, PAGE_2M);
        // a global entry, then one with e clear
        add_fill(32'h0080_0000, P4K, 10'd9, 1'b1, 20'h00777, 2'd3, 1'b1);
        add_fill(32'h00C0_0000, P4K, 10'd5, 1'b1, 20'h00888, 2'd1, 1'b0);
        add_lookup(1'b0, 1'b1, 2'd0, 10'd6, 32'h0080_0000, PAGE_4K, 32'h0040_6000, PAGE_4K);
        add_lookup(1'b0, 1'b1, 2'd0, 10'd5, 32'h00C0_0000, PAGE_4K, 32'h0080_0000, PAGE_4K);
        // fills 5 to 16, then fill 17 wraps onto entry 0
        for (k = 0; k < 12; k++) begin
            add_fill(32'h1000_0000 + k * 32'h2000, P4K, 10'd5, 1'b0,
                     20'h30000 + 20'(k), 2'(k), 1'b1);
        end
        add_fill(32'h0300_0000, P4K, 10'd5, 1'b0, 20'h44444, 2'd1, 1'b1);
        add_lookup(1'b0, 1'b1, 2'd0, 10'd5, 32'h0040_6000, PAGE_4K, 32'h0300_0000, PAGE_4K);
        add_lookup(1'b0, 1'b1, 2'd0, 10'd5, 32'h1001_6000, PAGE_4K, 32'h1460_0000, PAGE_2M);
        add_lookup(1'b0, 1'b0, 2'd0, 10'd5, 32'h0300_0000, PAGE_4K, 32'h1460_0000, PAGE_2M);
        add_lookup(1'b1, 1'b1, 2'd0, 10'd5, 32'h0300_0000, PAGE_4K, 32'h1460_0000, PAGE_2M);
        // this fill lands on entry 1 and evicts the 2 MiB page
        add_lookup(1'b0, 1'b1, 2'd0, 10'd5, 32'h0500_0000, PAGE_4K, 32'h1460_0000, PAGE_2M,
                   1'b1);
        add_fill(32'h0500_0000, P4K, 10'd5, 1'b0, 20'h55555, 2'd2, 1'b1);
        add_lookup(1'b0, 1'b1, 2'd0, 10'd5, 32'h0500_0000, PAGE_4K, 32'h1460_0000, PAGE_2M);
    endfunction

    task automatic check_result(input result_t e0, input result_t e1);
        check_paddr("s0_paddr", s0_paddr, e0.paddr);
        check_mat("s0_mat", s0_mat, e0.mat);
        check_hit("s0_hit", s0_hit, e0.hit);
        check_paddr("s1_paddr", s1_paddr, e1.paddr);
        check_mat("s1_mat", s1_mat, e1.mat);
        check_hit("s1_hit", s1_hit, e1.hit);
    endtask

    task automatic run_lookup(input int n);
        row_t    r;
        result_t e0;
        result_t e1;
        int      cycles;
        r = rows[n];
        crmd_da = r.da;
        crmd_pg = r.pg;
        crmd_plv = r.plv;
        asid = r.asid;
        dmw0 = r.win0;
        dmw1 = r.win1;
        s0_vaddr = r.s0_base | ($urandom & r.s0_mask);
        s1_vaddr = r.s1_base | ($urandom & r.s1_mask);
        e0 = model_port(r, s0_vaddr);
        e1 = model_port(r, s1_vaddr);
        req = 1'b1;
        if (r.with_fill) begin
            fill = rows[n + 1].entry;
            fill_req = 1'b1;
        end
        // count edges after the sampling edge until ack is seen
        @(posedge clk);
        cycles = 0;
        @(negedge clk);
        while (ack !== 1'b1) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles != 2) begin
            $display("** Error at %0.1f ns: ack latency is %0d cycles, expected 2",
                     $realtime, cycles);
            err_count++;
            fail_now("ack came at the wrong cycle");
        end
        if (fill_ack !== 1'b0) begin
            err_count++;
            fail_now("the fill was answered before the pending lookup");
        end
        check_result(e0, e1);
        @(negedge clk);
        check_result(e0, e1);
        req = 1'b0;
        while (ack !== 1'b0) @(negedge clk);
    endtask

    task automatic run_fill(input int n);
        fill = rows[n].entry;
        fill_req = 1'b1;
        while (fill_ack !== 1'b1) @(negedge clk);
        model_tlb[model_idx] = rows[n].entry;
        model_idx = (model_idx + 1) % `TLB_ENTRIES;
        fill_req = 1'b0;
        while (fill_ack !== 1'b0) @(negedge clk);
    endtask

    initial begin
        int n;
        void'($urandom(63));
        reset = 1'b1;
        req = 1'b0;
        fill_req = 1'b0;
        crmd_da = 1'b0;
        crmd_pg = 1'b0;
        crmd_plv = 2'd0;
        asid = 10'd0;
        dmw0 = '0;
        dmw1 = '0;
        fill = '0;
        s0_vaddr = '0;
        s1_vaddr = '0;
        err_count = 0;
        model_idx = 0;
        for (n = 0; n < `TLB_ENTRIES; n++) begin
            model_tlb[n] = '0;
        end
        build_table();
        rows_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (n = 0; n < rows.size(); n++) begin
            if (rows[n].is_fill) begin
                run_fill(n);
            end else begin
                run_lookup(n);
            end
        end
        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        wait (rows_ready);
        repeat (rows.size() * ROW_CYCLES + RESET_CYCLES) @(posedge clk);
        $display("timeout: the table did not finish within %0d cycles",
                 rows.size() * ROW_CYCLES + RESET_CYCLES);
        fail_now("watchdog expired");
    end

endmodule

`default_nettype wire

/* tlb_array.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mmu_defs.svh"

module tlb_array (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      we,
    input  wire [`TLB_IDX_W-1:0]     windex,
    input  wire mmu_pkg::tlb_entry_t wentry,
    input  wire [9:0]                asid,
    input  wire [`VA_W-1:0]          s0_vaddr,
    input  wire [`VA_W-1:0]          s1_vaddr,
    output logic                     s0_found,
    output logic                     s1_found,
    output logic [19:0]              s0_pfn,
    output logic [19:0]              s1_pfn,
    output mmu_pkg::ps_t             s0_found_ps,
    output mmu_pkg::ps_t             s1_found_ps,
    output mmu_pkg::mat_t            s0_tlb_mat,
    output mmu_pkg::mat_t            s1_tlb_mat
);
    import mmu_pkg::*;

    typedef struct packed {
        logic        found;
        logic [19:0] pfn;
        ps_t         ps;
        mat_t        mat;
    } lookup_t;

    tlb_entry_t              entries [`TLB_ENTRIES];
    logic [`TLB_ENTRIES-1:0] valid;
    lookup_t                 s0_res;
    lookup_t                 s1_res;

    // valid bits mirror the e field so that reset can clear every entry
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
        end else if (we) begin
            valid[windex] <= wentry.e;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            entries[windex] <= wentry;
        end
    end

    function automatic logic entry_match(
        input tlb_entry_t       ent,
        input logic [`VA_W-1:0] va,
        input logic [9:0]       cur_asid
    );
        logic tag_ok;
        // a 2 MiB page ignores vppn bits 7 to 0
        if (ent.ps == ps_t'(`PS_2M)) begin
            tag_ok = (ent.vppn[18:8] == va[31:21]);
        end else begin
            tag_ok = (ent.vppn == va[31:13]);
        end
        return tag_ok && (ent.g || ent.asid == cur_asid);
    endfunction

    function automatic lookup_t lookup(input logic [`VA_W-1:0] va);
        lookup_t res;
        res = '0;
        // scanned from the top, so the lowest matching index is kept
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
            if (valid[i] && entry_match(entries[i], va, asid)) begin
                res.found = 1'b1;
                res.pfn   = entries[i].pfn;
                res.ps    = entries[i].ps;
                res.mat   = entries[i].mat;
            end
        end
        return res;
    endfunction

    always_comb begin
        s0_res = lookup(s0_vaddr);
        s1_res = lookup(s1_vaddr);
    end

    assign s0_found    = s0_res.found;
    assign s0_pfn      = s0_res.pfn;
    assign s0_found_ps = s0_res.ps;
    assign s0_tlb_mat  = s0_res.mat;

    assign s1_found    = s1_res.found;
    assign s1_pfn      = s1_res.pfn;
    assign s1_found_ps = s1_res.ps;
    assign s1_tlb_mat  = s1_res.mat;

endmodule

`default_nettype wire

/* tlb_out.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mmu_defs.svh"

module tlb_out (
    input  wire mmu_pkg::ad_mode_t ad_mode,
    input  wire                    s0_dmw_hit,
    input  wire                    s1_dmw_hit,
    input  wire [`VA_W-1:0]        s0_vaddr,
    input  wire [`VA_W-1:0]        s1_vaddr,
    input  wire [`PA_W-1:0]        s0_dmw_paddr,
    input  wire [`PA_W-1:0]        s1_dmw_paddr,
    input  wire mmu_pkg::mat_t     s0_dmw_mat,
    input  wire mmu_pkg::mat_t     s1_dmw_mat,
    input  wire mmu_pkg::mat_t     s0_tlb_mat,
    input  wire mmu_pkg::mat_t     s1_tlb_mat,
    input  wire [19:0]             s0_pfn,
    input  wire [19:0]             s1_pfn,
    input  wire mmu_pkg::ps_t      s0_found_ps,
    input  wire mmu_pkg::ps_t      s1_found_ps,
    output logic [`PA_W-1:0]       s0_paddr,
    output logic [`PA_W-1:0]       s1_paddr,
    output mmu_pkg::mat_t          s0_mat,
    output mmu_pkg::mat_t          s1_mat,
    output logic                   s0_hit,
    output logic                   s1_hit
);
    import mmu_pkg::*;

    typedef struct packed {
        logic [`PA_W-1:0] paddr;
        mat_t             mat;
        logic             hit;
    } port_res_t;

    port_res_t s0_res;
    port_res_t s1_res;

    function automatic port_res_t select_port(
        input ad_mode_t         mode,
        input logic             dmw_hit,
        input logic [`VA_W-1:0] vaddr,
        input logic [`PA_W-1:0] dmw_paddr,
        input mat_t             dmw_mat,
        input mat_t             tlb_mat,
        input logic [19:0]      pfn,
        input ps_t              found_ps
    );
        port_res_t res;
        res = '0;
        case (mode)
            DIRECT: begin
                res.paddr = vaddr;
                res.hit   = 1'b1;
            end
            MAP: begin
                res.mat = dmw_hit ? dmw_mat : tlb_mat;
                res.hit = dmw_hit || found_ps == ps_t'(`PS_4K)
                          || found_ps == ps_t'(`PS_2M);
                if (dmw_hit) begin
                    res.paddr = dmw_paddr;
                end else begin
                    case (found_ps)
                        ps_t'(`PS_4K): res.paddr = {pfn, vaddr[11:0]};
                        ps_t'(`PS_2M): res.paddr = {pfn[19:9], vaddr[20:0]};
                        // a miss leaves the address at zero
                        default:       res.paddr = '0;
                    endcase
                end
            end
            default: res = '0;
        endcase
        return res;
    endfunction

    assign s0_res = select_port(ad_mode, s0_dmw_hit, s0_vaddr, s0_dmw_paddr,
                                s0_dmw_mat, s0_tlb_mat, s0_pfn, s0_found_ps);
    assign s1_res = select_port(ad_mode, s1_dmw_hit, s1_vaddr, s1_dmw_paddr,
                                s1_dmw_mat, s1_tlb_mat, s1_pfn, s1_found_ps);

    assign s0_paddr = s0_res.paddr;
    assign s0_mat   = s0_res.mat;
    assign s0_hit   = s0_res.hit;
    assign s1_paddr = s1_res.paddr;
    assign s1_mat   = s1_res.mat;
    assign s1_hit   = s1_res.hit;

endmodule

`default_nettype wire

/* translate_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module translate_ctrl (
    input  wire  clk,
    input  wire  reset,
    input  wire  req,
    input  wire  fill_req,
    output logic ack,
    output logic fill_ack,
    output logic addr_load,
    output logic result_load,
    output logic tlb_we,
    output logic fill_advance
);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        RESPOND,
        FILL_WRITE,
        FILL_DONE
    } state_t;

    state_t state;
    state_t state_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // a lookup request takes priority over a fill seen in the same cycle
    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (req) begin
                    state_next = LOOKUP;
                end else if (fill_req) begin
                    state_next = FILL_WRITE;
                end
            end
            LOOKUP:     state_next = RESPOND;
            RESPOND:    if (ack && !req) state_next = IDLE;
            FILL_WRITE: state_next = FILL_DONE;
            FILL_DONE:  if (fill_ack && !fill_req) state_next = IDLE;
            default:    state_next = IDLE;
        endcase
    end

    assign addr_load    = (state == IDLE) && req;
    assign result_load  = (state == LOOKUP);
    assign tlb_we       = (state == FILL_WRITE);
    assign fill_advance = (state == FILL_WRITE);

    // acks rise one cycle after the work is done and hold until the request drops
    always_ff @(posedge clk) begin
        if (reset) begin
            ack      <= 1'b0;
            fill_ack <= 1'b0;
        end else begin
            if (state == RESPOND && !ack) begin
                ack <= 1'b1;
            end else if (ack && !req) begin
                ack <= 1'b0;
            end
            if (state == FILL_DONE && !fill_ack) begin
                fill_ack <= 1'b1;
            end else if (fill_ack && !fill_req) begin
                fill_ack <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire
